// File: build.f
+incdir+verilog
verilog/mipsCtrlPkg.sv
verilog/instrDecoder.sv
verilog/ctrlSequencer.sv
verilog/ctrlWordGen.sv
verilog/mipsControl.sv
test/tbClockGen.sv
test/tbCtrlMonitor.sv
test/tbMipsControl.sv

// File: test/tbClockGen.sv
`timescale 1ns/1ns
`default_nettype none

module tbClockGen #(
    parameter int HalfPeriod  = 4,
    parameter int ResetCycles = 3
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

    always #HalfPeriod clk = ~clk; // 8 ns period

endmodule

`default_nettype wire

// File: test/tbCtrlMonitor.sv
`timescale 1ns/1ns
`default_nettype none
`include "mipsCtrl_defs.svh"

module tbCtrlMonitor import mipsCtrlPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  ctrlWord_t  ctrl,
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    input  logic       overflow,
    input  logic       expValid,
    input  logic [7:0] expLen,
    input  ctrlWord_t  expWord,
    output int         passCount,
    output int         failCount
);

    ctrlWord_t   want;
    ctrlWord_t   resetWord;
    ctrlWord_t   wbSeen;     // word at the regWrite cycle
    ctrlWord_t   memSeen;
    ctrlWord_t   brSeen;
    ctrlWord_t   pcSeen;     // first pcWrite after irWrite
    logic [7:0]  wantLen;
    logic [12:0] instrBits;
    logic        active;
    int          cyc;
    int          lastIr;
    int          testErrs;
    int          resetStage;
    int          wbCnt;
    int          memCnt;
    int          brCnt;
    int          pcCnt;
    int          epcCnt;
    int          mulCnt;
    int          hiLoCnt;
    int          mulAt;
    int          hiLoAt;

    initial begin
        passCount = 0;
        failCount = 0;
        testErrs  = 0;
        resetWord = '0;
        resetWord.regs.regWrite = 1'b1;
        resetWord.regs.regDst   = `DST_SP;
        resetWord.regs.memToReg = `WB_STACKTOP;
    end

    task automatic checkField(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            testErrs++;
        end
    endtask

    task automatic closeTest(input string label);
        if (testErrs == 0) begin
            passCount++;
            $display("%s: ok", label);
        end else begin
            failCount++;
            $display("%s: %0d errors", label, testErrs);
        end
        testErrs = 0;
    endtask

    task automatic clearEvents();
        wbCnt   = 0;
        memCnt  = 0;
        brCnt   = 0;
        pcCnt   = 0;
        epcCnt  = 0;
        mulCnt  = 0;
        hiLoCnt = 0;
    endtask

    task automatic finishInstr();
        checkField("instruction length", cyc - lastIr, wantLen);
        checkField("regWrite count", wbCnt, want.regs.regWrite);
        if (want.regs.regWrite && wbCnt == 1) begin
            checkField("regDst", wbSeen.regs.regDst, want.regs.regDst);
            checkField("memToReg", wbSeen.regs.memToReg, want.regs.memToReg);
            checkField("twoBytes", wbSeen.mem.twoBytes, want.mem.twoBytes);
            checkField("store", wbSeen.mem.store, want.mem.store);
        end
        checkField("memWrite count", memCnt, want.mem.memWrite);
        if (want.mem.memWrite && memCnt == 1) begin
            checkField("store", memSeen.mem.store, want.mem.store);
            checkField("twoBytes", memSeen.mem.twoBytes, want.mem.twoBytes);
        end
        checkField("pcWriteCond count", brCnt, want.pc.pcWriteCond);
        if (want.pc.pcWriteCond && brCnt == 1) begin
            checkField("pcSrc", brSeen.pc.pcSrc, want.pc.pcSrc);
            checkField("eqOrNe", brSeen.pc.eqOrNe, want.pc.eqOrNe);
            checkField("gtOrLt", brSeen.pc.gtOrLt, want.pc.gtOrLt);
        end
        // next fetch1 adds one more pcWrite
        checkField("pcWrite count", pcCnt, want.pc.pcWrite + 1);
        if (want.pc.pcWrite && pcCnt == 2) begin
            checkField("pcSrc", pcSeen.pc.pcSrc, want.pc.pcSrc);
            if (want.pc.pcSrc == `PCSRC_ALU) begin
                checkField("aluOp", pcSeen.alu.aluOp, want.alu.aluOp);
            end
        end
        checkField("epcWrite count", epcCnt, want.regs.epcWrite);
        checkField("multInit count", mulCnt, want.mul.multInit);
        checkField("hiLoWrite count", hiLoCnt, want.mul.multInit);
        if (want.mul.multInit && mulCnt == 1 && hiLoCnt == 1) begin
            checkField("multInit to hiLoWrite", hiLoAt - mulAt, `MUL_WAIT_CYCLES + 1);
        end
        closeTest($sformatf("instr %0d op=%h fn=%h ovf=%b len=%0d", passCount + failCount,
                            instrBits[12:7], instrBits[6:1], instrBits[0], cyc - lastIr));
    endtask

    always @(negedge clk) begin
        if (!rstN) begin
            resetStage = 0;
            active     = 1'b0;
            cyc        = 0;
            lastIr     = 0;
            clearEvents();
        end else if (resetStage == 0) begin
            checkField("ctrl", ctrl, resetWord); // stack pointer load
            resetStage = 1;
        end else if (resetStage == 1) begin
            checkField("pcWrite", ctrl.pc.pcWrite, 1'b1);
            checkField("pcSrc", ctrl.pc.pcSrc, `PCSRC_ALU);
            closeTest("reset and first fetch");
            resetStage = 2;
        end else begin
            cyc++;
            if (ctrl.regs.irWrite) begin
                if (active) finishInstr();
                active = 1'b0;
                lastIr = cyc;
                clearEvents();
            end else begin
                if (expValid) begin // decode cycle of the new row
                    want      = expWord;
                    wantLen   = expLen;
                    instrBits = {opcode, funct, overflow};
                    active    = 1'b1;
                end
                if (ctrl.regs.regWrite) begin
                    wbCnt++;
                    wbSeen = ctrl;
                end
                if (ctrl.mem.memWrite) begin
                    memCnt++;
                    memSeen = ctrl;
                end
                if (ctrl.pc.pcWriteCond) begin
                    brCnt++;
                    brSeen = ctrl;
                end
                if (ctrl.pc.pcWrite) begin
                    if (pcCnt == 0) pcSeen = ctrl;
                    pcCnt++;
                end
                if (ctrl.regs.epcWrite) epcCnt++;
                if (ctrl.mul.multInit) begin
                    mulCnt++;
                    mulAt = cyc;
                end
                if (ctrl.mul.hiLoWrite) begin
                    hiLoCnt++;
                    hiLoAt = cyc;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tbMipsControl.sv
`timescale 1ns/1ns
`default_nettype none
`include "mipsCtrl_defs.svh"

module tbMipsControl import mipsCtrlPkg::*; ();

    localparam int NumRows  = 27;
    localparam int NumPicks = 20;
    localparam int ClkNs    = 8;

    typedef struct packed {
        logic [5:0] opcode;
        logic [5:0] funct;
        logic       ovf;
        logic [7:0] len;    // fetch1 to next fetch1
        ctrlWord_t  want;
    } tableRow_t;

    logic        clk;
    logic        rstN;
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic        overflow;
    ctrlWord_t   ctrl;
    logic        expValid;
    logic [7:0]  expLen;
    ctrlWord_t   expWord;
    int          passCount;
    int          failCount;
    tableRow_t   rows [NumRows];
    int          order [$];
    int unsigned watchLimit = 0;
    logic [31:0] lfsr = 32'h2dc4_c51d;

    tbClockGen clkGen0 (.clk(clk), .rstN(rstN));

    mipsControl dut0 (
        .clk      (clk),
        .rstN     (rstN),
        .opcode   (opcode),
        .funct    (funct),
        .overflow (overflow),
        .ctrl     (ctrl)
    );

    tbCtrlMonitor monitor0 (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .opcode    (opcode),
        .funct     (funct),
        .overflow  (overflow),
        .expValid  (expValid),
        .expLen    (expLen),
        .expWord   (expWord),
        .passCount (passCount),
        .failCount (failCount)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic ctrlWord_t wbWord(input logic [1:0] dst, input logic [3:0] src,
                                         input logic two);
        ctrlWord_t w;
        w = '0;
        w.regs.regWrite = 1'b1;
        w.regs.regDst   = dst;
        w.regs.memToReg = src;
        w.mem.twoBytes  = two;
        return w;
    endfunction

    function automatic ctrlWord_t storeWord(input logic partial, input logic two);
        ctrlWord_t w;
        w = '0;
        w.mem.memWrite = 1'b1;
        w.mem.store    = partial;
        w.mem.twoBytes = two;
        return w;
    endfunction

    function automatic ctrlWord_t branchWord(input logic [1:0] eq, input logic [1:0] gt);
        ctrlWord_t w;
        w = '0;
        w.pc.pcWriteCond = 1'b1;
        w.pc.pcSrc       = `PCSRC_TARGET;
        w.pc.eqOrNe      = eq;
        w.pc.gtOrLt      = gt;
        return w;
    endfunction

    function automatic ctrlWord_t jumpWord(input logic [2:0] src, input logic link);
        ctrlWord_t w;
        w = '0;
        w.pc.pcWrite = 1'b1;
        w.pc.pcSrc   = src;
        if (link) begin // jal writes ra first
            w.regs.regWrite = 1'b1;
            w.regs.regDst   = `DST_RA;
            w.regs.memToReg = `WB_PCLINK;
        end
        return w;
    endfunction

    function automatic ctrlWord_t excWord();
        ctrlWord_t w;
        w = '0;
        w.regs.epcWrite = 1'b1;
        w.pc.pcWrite    = 1'b1;
        w.pc.pcSrc      = `PCSRC_VECTOR;
        return w;
    endfunction

    function automatic ctrlWord_t multWord();
        ctrlWord_t w;
        w = '0;
        w.mul.multInit = 1'b1;
        return w;
    endfunction

    function automatic tableRow_t makeRow(input logic [5:0] op, input logic [5:0] fn,
                                          input logic ovf, input int len, input ctrlWord_t w);
        tableRow_t r;
        r.opcode = op;
        r.funct  = fn;
        r.ovf    = ovf;
        r.len    = len[7:0];
        r.want   = w;
        return r;
    endfunction

    task automatic fillTable();
        rows[0]  = makeRow(`OP_RTYPE, `FN_ADD, 0, 6, wbWord(`DST_RD, `WB_ALUOUT, 0));
        rows[1]  = makeRow(`OP_RTYPE, `FN_SUB, 0, 6, wbWord(`DST_RD, `WB_ALUOUT, 0));
        rows[2]  = makeRow(`OP_RTYPE, `FN_AND, 0, 6, wbWord(`DST_RD, `WB_ALUOUT, 0));
        rows[3]  = makeRow(`OP_RTYPE, `FN_SLT, 0, 6, wbWord(`DST_RD, `WB_ALUOUT, 0));
        rows[4]  = makeRow(`OP_ADDI, 6'h00, 0, 6, wbWord(`DST_RT, `WB_ALUOUT, 0));
        rows[5]  = makeRow(`OP_ADDIU, 6'h00, 0, 6, wbWord(`DST_RT, `WB_ALUOUT, 0));
        rows[6]  = makeRow(`OP_SLTI, 6'h00, 0, 6, wbWord(`DST_RT, `WB_ALUOUT, 0));
        rows[7]  = makeRow(`OP_RTYPE, `FN_ADD, 1, 9, excWord());
        rows[8]  = makeRow(`OP_RTYPE, `FN_SUB, 1, 9, excWord());
        rows[9]  = makeRow(`OP_ADDI, 6'h00, 1, 9, excWord());
        rows[10] = makeRow(`OP_ADDIU, 6'h00, 1, 6, wbWord(`DST_RT, `WB_ALUOUT, 0));
        rows[11] = makeRow(`OP_LW, 6'h00, 0, 9, wbWord(`DST_RT, `WB_MDRWORD, 0));
        rows[12] = makeRow(`OP_LH, 6'h00, 0, 9, wbWord(`DST_RT, `WB_MDRPART, 1));
        rows[13] = makeRow(`OP_LB, 6'h00, 0, 9, wbWord(`DST_RT, `WB_MDRPART, 0));
        rows[14] = makeRow(`OP_SW, 6'h00, 0, 6, storeWord(0, 0));
        rows[15] = makeRow(`OP_SH, 6'h00, 0, 9, storeWord(1, 1));
        rows[16] = makeRow(`OP_SB, 6'h00, 0, 9, storeWord(1, 0));
        rows[17] = makeRow(`OP_BEQ, 6'h00, 0, 5, branchWord(2'd2, 2'd0));
        rows[18] = makeRow(`OP_BNE, 6'h00, 0, 5, branchWord(2'd1, 2'd0));
        rows[19] = makeRow(`OP_BGT, 6'h00, 0, 5, branchWord(2'd0, 2'd2));
        rows[20] = makeRow(`OP_BLE, 6'h00, 0, 5, branchWord(2'd0, 2'd1));
        rows[21] = makeRow(`OP_J, 6'h00, 0, 5, jumpWord(`PCSRC_JUMP, 0));
        rows[22] = makeRow(`OP_RTYPE, `FN_JR, 0, 5, jumpWord(`PCSRC_ALU, 0));
        rows[23] = makeRow(`OP_JAL, 6'h00, 0, 6, jumpWord(`PCSRC_JUMP, 1));
        rows[24] = makeRow(`OP_RTYPE, `FN_MULT, 0, 4 + 1 + `MUL_WAIT_CYCLES + 1, multWord());
        rows[25] = makeRow(6'h3f, 6'h00, 0, 8, excWord());
        rows[26] = makeRow(`OP_RTYPE, 6'h00, 0, 8, excWord()); // sll is gone
    endtask

    task automatic pickRow(output int idx);
        logic [4:0] bits;
        bits = '0;
        for (int b = 0; b < 5; b++) begin
            lfsr = nextLfsr(lfsr);
            bits = {bits[3:0], lfsr[0]};
        end
        idx = bits % NumRows;
    endtask

    task automatic waitIrWrite();
        do @(negedge clk); while (ctrl.regs.irWrite !== 1'b1);
    endtask

    // new fields land in decode
    task automatic applyRow(input int idx);
        waitIrWrite();
        @(posedge clk);
        opcode   <= rows[idx].opcode;
        funct    <= rows[idx].funct;
        overflow <= rows[idx].ovf;
        expLen   <= rows[idx].len;
        expWord  <= rows[idx].want;
        expValid <= 1'b1;
        @(posedge clk);
        expValid <= 1'b0;
    endtask

    initial begin
        int total;
        int idx;
        opcode   = `OP_RTYPE;
        funct    = 6'h00;
        overflow = 1'b0;
        expValid = 1'b0;
        expLen   = '0;
        expWord  = '0;
        fillTable();
        for (int i = 0; i < NumRows; i++) order.push_back(i);
        for (int i = 0; i < NumPicks; i++) begin
            pickRow(idx);
            order.push_back(idx);
        end
        total = 0;
        foreach (order[i]) total += rows[order[i]].len;
        watchLimit = 2 * total * ClkNs + 200;
        wait (rstN === 1'b1);
        foreach (order[i]) applyRow(order[i]);
        waitIrWrite(); // closes the last instruction
        @(posedge clk);
        $display("%0d tests passed, %0d failed", passCount, failCount);
        if (failCount == 0 && passCount == order.size() + 1) begin
            $display("Simulation PASSED");
        end else begin
            if (passCount + failCount != order.size() + 1) begin
                $display("monitor closed %0d tests instead of %0d",
                         passCount + failCount, order.size() + 1);
            end
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        wait (watchLimit != 0);
        #(watchLimit);
        $display("watchdog expired after %0d ns before the sequence finished", watchLimit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/ctrlSequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "mipsCtrl_defs.svh"

module ctrlSequencer import mipsCtrlPkg::*; (
    input  logic                clk,
    input  logic                rstN,
    input  instrClass_t         instrClass,
    input  logic                overflow,
    output logic [`STATE_W-1:0] state
);

    localparam int CntW = $clog2(`MUL_WAIT_CYCLES);

    logic [`STATE_W-1:0] nextState;
    logic [CntW-1:0]     waitCnt;

    always_comb begin
        nextState = `ST_FETCH1;
        case (state)
            `ST_RESET:  nextState = `ST_FETCH1;
            `ST_FETCH1: nextState = `ST_FETCH2;
            `ST_FETCH2: nextState = `ST_FETCH3;
            `ST_FETCH3: nextState = `ST_DECODE;
            `ST_DECODE: begin
                case (1'b1)
                    instrClass.isAdd:   nextState = `ST_ADD;
                    instrClass.isSub:   nextState = `ST_SUB;
                    instrClass.isAnd:   nextState = `ST_AND;
                    instrClass.isSlt:   nextState = `ST_SLT;
                    instrClass.isAddi:  nextState = `ST_ADDI;
                    instrClass.isAddiu: nextState = `ST_ADDIU;
                    instrClass.isSlti:  nextState = `ST_SLTI;
                    instrClass.isLw,
                    instrClass.isLh,
                    instrClass.isLb,
                    instrClass.isSw,
                    instrClass.isSh,
                    instrClass.isSb:    nextState = `ST_MEM_ADDR;
                    instrClass.isBeq:   nextState = `ST_BEQ;
                    instrClass.isBne:   nextState = `ST_BNE;
                    instrClass.isBgt:   nextState = `ST_BGT;
                    instrClass.isBle:   nextState = `ST_BLE;
                    instrClass.isJ:     nextState = `ST_JUMP;
                    instrClass.isJal:   nextState = `ST_JAL;
                    instrClass.isJr:    nextState = `ST_JR;
                    instrClass.isMult:  nextState = `ST_MUL_START;
                    instrClass.illegal: nextState = `ST_EXC_ENTRY;
                    default:            nextState = `ST_EXC_ENTRY;
                endcase
            end
            `ST_ADD,
            `ST_SUB:   nextState = overflow ? `ST_EXC_ENTRY : `ST_RTYPE_WB;
            `ST_AND,
            `ST_SLT:   nextState = `ST_RTYPE_WB;
            `ST_ADDI:  nextState = overflow ? `ST_EXC_ENTRY : `ST_IMM_WB;
            `ST_ADDIU,
            `ST_SLTI:  nextState = `ST_IMM_WB; // addiu never traps
            `ST_EXC_ENTRY: nextState = `ST_EXC_LOAD1;
            `ST_EXC_LOAD1: nextState = `ST_EXC_LOAD2;
            `ST_EXC_LOAD2: nextState = `ST_EXC_JUMP;
            `ST_MEM_ADDR:  nextState = instrClass.isSw ? `ST_SW : `ST_MEM_READ;
            `ST_MEM_READ:  nextState = `ST_MEM_WAIT;
            `ST_MEM_WAIT:  nextState = `ST_MDR_LOAD;
            `ST_MDR_LOAD: begin
                // halfword and byte stores come back here for the merge
                case (1'b1)
                    instrClass.isLh: nextState = `ST_LH;
                    instrClass.isLb: nextState = `ST_LB;
                    instrClass.isSh: nextState = `ST_SH;
                    instrClass.isSb: nextState = `ST_SB;
                    default:         nextState = `ST_LW;
                endcase
            end
            `ST_JAL:       nextState = `ST_JUMP;
            `ST_MUL_START: nextState = `ST_MUL_WAIT;
            `ST_MUL_WAIT:  nextState = (waitCnt == '0) ? `ST_MUL_STORE : `ST_MUL_WAIT;
            default:       nextState = `ST_FETCH1; // last state of every instruction
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= `ST_RESET;
            waitCnt <= '0;
        end else begin
            state <= nextState;
            if (state == `ST_MUL_START) begin
                waitCnt <= CntW'(`MUL_WAIT_CYCLES - 1);
            end else if (state == `ST_MUL_WAIT && waitCnt != '0) begin
                waitCnt <= waitCnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/ctrlWordGen.sv
`timescale 1ns/1ns
`default_nettype none
`include "mipsCtrl_defs.svh"

module ctrlWordGen import mipsCtrlPkg::*; (
    input  logic [`STATE_W-1:0] state,
    output ctrlWord_t           ctrl
);

    always_comb begin
        ctrl = '0;
        case (state)
            `ST_RESET: begin // stack pointer load
                ctrl.regs.regWrite = 1'b1;
                ctrl.regs.regDst   = `DST_SP;
                ctrl.regs.memToReg = `WB_STACKTOP;
            end
            `ST_FETCH1: begin // PC + 4
                ctrl.pc.pcWrite   = 1'b1;
                ctrl.pc.pcSrc     = `PCSRC_ALU;
                ctrl.mem.iOrD     = `IORD_PC;
                ctrl.alu.aluSrcB  = `SRCB_FOUR;
                ctrl.alu.aluOp    = `ALUOP_ADD;
            end
            `ST_FETCH2: ; // memory latency
            `ST_FETCH3: ctrl.regs.irWrite = 1'b1;
            `ST_DECODE: begin
                ctrl.alu.aluSrcB     = `SRCB_BROFF; // branch target into ALUOut
                ctrl.alu.aluOp       = `ALUOP_ADD;
                ctrl.alu.aluOutWrite = 1'b1;
                ctrl.regs.regALoad   = 1'b1;
                ctrl.regs.regBLoad   = 1'b1;
            end
            `ST_ADD, `ST_SUB, `ST_AND, `ST_SLT: begin
                ctrl.alu.aluSrcA     = 1'b1;
                ctrl.alu.aluSrcB     = `SRCB_REG;
                ctrl.alu.aluOutWrite = 1'b1;
                case (state)
                    `ST_ADD: ctrl.alu.aluOp = `ALUOP_ADD;
                    `ST_SUB: ctrl.alu.aluOp = `ALUOP_SUB;
                    `ST_AND: ctrl.alu.aluOp = `ALUOP_AND;
                    default: ctrl.alu.aluOp = `ALUOP_CMP;
                endcase
                ctrl.alu.aluOutSrc = (state == `ST_SLT);
            end
            `ST_ADDI, `ST_ADDIU, `ST_MEM_ADDR: begin // A + imm
                ctrl.alu.aluSrcA     = 1'b1;
                ctrl.alu.aluSrcB     = `SRCB_IMM;
                ctrl.alu.aluOp       = `ALUOP_ADD;
                ctrl.alu.aluOutWrite = 1'b1;
            end
            `ST_SLTI: begin
                ctrl.alu.aluSrcA     = 1'b1;
                ctrl.alu.aluSrcB     = `SRCB_IMM;
                ctrl.alu.aluOp       = `ALUOP_CMP;
                ctrl.alu.aluOutSrc   = 1'b1;
                ctrl.alu.aluOutWrite = 1'b1;
            end
            `ST_RTYPE_WB, `ST_IMM_WB: begin
                ctrl.regs.regWrite = 1'b1;
                ctrl.regs.regDst   = (state == `ST_RTYPE_WB) ? `DST_RD : `DST_RT;
                ctrl.regs.memToReg = `WB_ALUOUT;
            end
            `ST_EXC_ENTRY: begin // EPC gets PC - 4
                ctrl.mem.iOrD      = `IORD_VECTOR;
                ctrl.alu.aluSrcB   = `SRCB_FOUR;
                ctrl.alu.aluOp     = `ALUOP_SUB;
                ctrl.regs.epcWrite = 1'b1;
            end
            `ST_EXC_LOAD1: ctrl.mem.iOrD = `IORD_VECTOR;
            `ST_EXC_LOAD2: begin
                ctrl.mem.iOrD    = `IORD_VECTOR;
                ctrl.mem.mdrLoad = 1'b1;
            end
            `ST_EXC_JUMP: begin // handler address from MDR
                ctrl.pc.pcWrite = 1'b1;
                ctrl.pc.pcSrc   = `PCSRC_VECTOR;
            end
            `ST_MEM_READ, `ST_MEM_WAIT: ctrl.mem.iOrD = `IORD_ALUOUT;
            `ST_MDR_LOAD: begin
                ctrl.mem.iOrD    = `IORD_ALUOUT;
                ctrl.mem.mdrLoad = 1'b1;
            end
            `ST_LW, `ST_LH, `ST_LB: begin
                ctrl.regs.regWrite = 1'b1;
                ctrl.regs.regDst   = `DST_RT;
                ctrl.regs.memToReg = (state == `ST_LW) ? `WB_MDRWORD : `WB_MDRPART;
                ctrl.mem.twoBytes  = (state == `ST_LH);
            end
            `ST_SW, `ST_SH, `ST_SB: begin
                ctrl.mem.iOrD     = `IORD_ALUOUT;
                ctrl.mem.memWrite = 1'b1;
                ctrl.mem.store    = (state != `ST_SW); // partial store merges B into MDR
                ctrl.mem.wdSrc    = (state != `ST_SW);
                ctrl.mem.twoBytes = (state == `ST_SH);
            end
            `ST_BEQ, `ST_BNE, `ST_BGT, `ST_BLE: begin
                ctrl.pc.pcWriteCond = 1'b1;
                ctrl.pc.pcSrc       = `PCSRC_TARGET;
                ctrl.alu.aluSrcA    = 1'b1;
                ctrl.alu.aluSrcB    = `SRCB_REG;
                case (state)
                    `ST_BEQ: ctrl.pc.eqOrNe = 2'd2;
                    `ST_BNE: ctrl.pc.eqOrNe = 2'd1;
                    `ST_BGT: ctrl.pc.gtOrLt = 2'd2;
                    default: ctrl.pc.gtOrLt = 2'd1;
                endcase
                ctrl.alu.aluOp = (state == `ST_BEQ || state == `ST_BNE) ? `ALUOP_SUB
                                                                          : `ALUOP_CMP;
            end
            `ST_JAL: begin // link before the jump
                ctrl.regs.regWrite = 1'b1;
                ctrl.regs.regDst   = `DST_RA;
                ctrl.regs.memToReg = `WB_PCLINK;
            end
            `ST_JUMP: begin
                ctrl.pc.pcWrite = 1'b1;
                ctrl.pc.pcSrc   = `PCSRC_JUMP;
            end
            `ST_JR: begin // rs straight through the ALU
                ctrl.pc.pcWrite  = 1'b1;
                ctrl.pc.pcSrc    = `PCSRC_ALU;
                ctrl.alu.aluSrcA = 1'b1;
                ctrl.alu.aluOp   = `ALUOP_PASS;
            end
            `ST_MUL_START: ctrl.mul.multInit = 1'b1;
            `ST_MUL_WAIT: ;
            `ST_MUL_STORE: begin
                ctrl.mul.hiLoWrite = 1'b1;
                ctrl.mul.hiLoSrc   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "mipsCtrl_defs.svh"

module instrDecoder import mipsCtrlPkg::*; (
    input  logic [5:0]  opcode,
    input  logic [5:0]  funct,
    output instrClass_t instrClass
);

    always_comb begin
        instrClass = '0;
        case (opcode)
            `OP_RTYPE: begin
                case (funct)
                    `FN_ADD:  instrClass.isAdd  = 1'b1;
                    `FN_SUB:  instrClass.isSub  = 1'b1;
                    `FN_AND:  instrClass.isAnd  = 1'b1;
                    `FN_SLT:  instrClass.isSlt  = 1'b1;
                    `FN_JR:   instrClass.isJr   = 1'b1;
                    `FN_MULT: instrClass.isMult = 1'b1;
                    default:  instrClass.illegal = 1'b1; // shifts, div, break, rte too
                endcase
            end
            `OP_ADDI:  instrClass.isAddi  = 1'b1;
            `OP_ADDIU: instrClass.isAddiu = 1'b1;
            `OP_SLTI:  instrClass.isSlti  = 1'b1;
            `OP_LW:    instrClass.isLw    = 1'b1;
            `OP_LH:    instrClass.isLh    = 1'b1;
            `OP_LB:    instrClass.isLb    = 1'b1;
            `OP_SW:    instrClass.isSw    = 1'b1;
            `OP_SH:    instrClass.isSh    = 1'b1;
            `OP_SB:    instrClass.isSb    = 1'b1;
            `OP_BEQ:   instrClass.isBeq   = 1'b1;
            `OP_BNE:   instrClass.isBne   = 1'b1;
            `OP_BGT:   instrClass.isBgt   = 1'b1;
            `OP_BLE:   instrClass.isBle   = 1'b1;
            `OP_J:     instrClass.isJ     = 1'b1;
            `OP_JAL:   instrClass.isJal   = 1'b1;
            default:   instrClass.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/mipsControl.sv
`timescale 1ns/1ns
`default_nettype none
`include "mipsCtrl_defs.svh"

module mipsControl import mipsCtrlPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    input  logic       overflow,
    output ctrlWord_t  ctrl
);

    instrClass_t         instrClass;
    logic [`STATE_W-1:0] state;

    instrDecoder decoder0 (
        .opcode     (opcode),
        .funct      (funct),
        .instrClass (instrClass)
    );

    ctrlSequencer sequencer0 (
        .clk        (clk),
        .rstN       (rstN),
        .instrClass (instrClass),
        .overflow   (overflow),
        .state      (state)
    );

    // Moore outputs, state only
    ctrlWordGen wordGen0 (
        .state (state),
        .ctrl  (ctrl)
    );

endmodule

`default_nettype wire

// File: verilog/mipsCtrlPkg.sv
`default_nettype none

package mipsCtrlPkg;

    // one flag per supported instruction
    typedef struct packed {
        logic isAdd;
        logic isSub;
        logic isAnd;
        logic isSlt;
        logic isAddi;
        logic isAddiu;
        logic isSlti;
        logic isLw;
        logic isLh;
        logic isLb;
        logic isSw;
        logic isSh;
        logic isSb;
        logic isBeq;
        logic isBne;
        logic isBgt;
        logic isBle;
        logic isJ;
        logic isJal;
        logic isJr;
        logic isMult;
        logic illegal;
    } instrClass_t;

    typedef struct packed {
        logic       pcWrite;
        logic       pcWriteCond;
        logic [2:0] pcSrc;
        logic [1:0] eqOrNe;      // 2 = taken on equal
        logic [1:0] gtOrLt;      // 2 = taken on greater
    } pcCtrl_t;

    typedef struct packed {
        logic [2:0] iOrD;
        logic       memWrite;
        logic       mdrLoad;
        logic       store;       // merge into read word
        logic       twoBytes;
        logic       wdSrc;
    } memCtrl_t;

    typedef struct packed {
        logic       aluSrcA;     // 0 = PC, 1 = reg A
        logic [1:0] aluSrcB;
        logic [2:0] aluOp;
        logic       aluOutSrc;   // compare flag instead of result
        logic       aluOutWrite;
        logic       gLtMux;
    } aluCtrl_t;

    typedef struct packed {
        logic       irWrite;
        logic       regALoad;
        logic       regBLoad;
        logic       regWrite;
        logic [1:0] regDst;
        logic [3:0] memToReg;
        logic       epcWrite;
    } regCtrl_t;

    typedef struct packed {
        logic multInit;
        logic hiLoWrite;
        logic hiLoSrc;
    } mulCtrl_t;

    typedef struct packed {
        pcCtrl_t  pc;
        memCtrl_t mem;
        aluCtrl_t alu;
        regCtrl_t regs;
        mulCtrl_t mul;
    } ctrlWord_t;

endpackage

`default_nettype wire

// File: verilog/mipsCtrl_defs.svh
`ifndef MIPSCTRL_DEFS_SVH
`define MIPSCTRL_DEFS_SVH

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_BLE   6'h06
`define OP_BGT   6'h07
`define OP_ADDI  6'h08
`define OP_ADDIU 6'h09
`define OP_SLTI  6'h0a
`define OP_LB    6'h20
`define OP_LH    6'h21
`define OP_LW    6'h23
`define OP_SB    6'h28
`define OP_SH    6'h29
`define OP_SW    6'h2b

// funct field, R-type only
`define FN_JR   6'h08
`define FN_MULT 6'h18
`define FN_ADD  6'h20
`define FN_SUB  6'h22
`define FN_AND  6'h24
`define FN_SLT  6'h2a

`define STATE_W 8

`define ST_RESET     8'd0
`define ST_FETCH1    8'd1
`define ST_FETCH2    8'd2
`define ST_FETCH3    8'd3
`define ST_DECODE    8'd4
`define ST_ADD       8'd5
`define ST_RTYPE_WB  8'd6
`define ST_EXC_ENTRY 8'd7
`define ST_IMM_WB    8'd8
`define ST_AND       8'd10
`define ST_EXC_LOAD1 8'd12
`define ST_EXC_LOAD2 8'd13
`define ST_EXC_JUMP  8'd14
`define ST_MEM_ADDR  8'd15
`define ST_MEM_READ  8'd16
`define ST_SW        8'd17
`define ST_MEM_WAIT  8'd18
`define ST_MDR_LOAD  8'd19
`define ST_LW        8'd20
`define ST_LH        8'd21
`define ST_LB        8'd22
`define ST_SH        8'd23
`define ST_SB        8'd24
`define ST_SUB       8'd44
`define ST_SLT       8'd47
`define ST_SLTI      8'd49
`define ST_BEQ       8'd53
`define ST_BNE       8'd54
`define ST_BGT       8'd56
`define ST_BLE       8'd57
`define ST_JAL       8'd59
`define ST_JUMP      8'd60
`define ST_JR        8'd61
`define ST_MUL_START 8'd62
`define ST_MUL_STORE 8'd63
`define ST_ADDI      8'd73
`define ST_MUL_WAIT  8'd74
`define ST_ADDIU     8'd75

`define ALUOP_PASS 3'd0
`define ALUOP_ADD  3'd1
`define ALUOP_SUB  3'd2
`define ALUOP_AND  3'd3
`define ALUOP_CMP  3'd7

`define PCSRC_ALU    3'd0
`define PCSRC_TARGET 3'd1
`define PCSRC_JUMP   3'd2
`define PCSRC_VECTOR 3'd3

`define WB_ALUOUT   4'd0
`define WB_MDRWORD  4'd1
`define WB_MDRPART  4'd2
`define WB_PCLINK   4'd6
`define WB_STACKTOP 4'd7

`define DST_RT 2'd0
`define DST_RD 2'd1
`define DST_RA 2'd2
`define DST_SP 2'd3

// ALU B operand and memory address selects
`define SRCB_REG    2'd0
`define SRCB_FOUR   2'd1
`define SRCB_IMM    2'd2
`define SRCB_BROFF  2'd3
`define IORD_PC     3'd0
`define IORD_ALUOUT 3'd1
`define IORD_VECTOR 3'd2

`define MUL_WAIT_CYCLES 33

`endif
